/* hw/uart_pkg.sv */
/* shared timing constants and types for the 8N1 UART; the bit period is fixed here
   at 16 clocks for simulation, so a board build must edit clks_per_bit. */

package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int clks_per_bit = 16;             // clock cycles per serial bit.
    localparam int half_bit = clks_per_bit / 2;   // offset from an edge to mid-bit.
    localparam int data_bits = 8;                 // payload bits per frame.

    // start + data + stop, in clock cycles.
    localparam int frame_clks = 10 * clks_per_bit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] baud_cnt_t;   // bit-period counter, wide enough for a board divisor.
    typedef logic [7:0] uart_byte_t;   // one data byte.

    // transmit FSM.
    typedef enum logic [1:0] {
        tx_idle,    // line high, waiting for a start strobe.
        tx_start,   // driving the low start bit.
        tx_data,    // shifting data out, lsb first.
        tx_stop     // driving the high stop bit.
    } tx_state_t;

    // receive FSM.
    typedef enum logic [1:0] {
        rx_idle,    // waiting for a falling edge.
        rx_start,   // counting to the middle of the start bit.
        rx_data,    // sampling data bits at mid-bit.
        rx_stop     // sampling and checking the stop bit.
    } rx_state_t;

endpackage : uart_pkg

/* hw/uart_tx.sv */
/* 8N1 serializer; start is only honoured in idle and must not pulse while busy.
   busy rises the cycle after start and stays high for exactly one frame. */

`timescale 1ns/1ps

module uart_tx (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,     // one-cycle strobe, byte_in valid with it.
    input  uart_pkg::uart_byte_t  byte_in,
    output logic                  line,      // serial output, idles high.
    output logic                  busy       // high while a frame is on the line.
);

    import uart_pkg::*;

    tx_state_t  state;
    baud_cnt_t  baud_cnt;      // cycles spent in the current bit.
    logic [2:0] bit_idx;       // data bit being sent.
    uart_byte_t shift_q;       // remaining data bits, next one in bit 0.
    logic       bit_end;

    // last cycle of the current bit period.
    assign bit_end = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= tx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            line     <= 1'b1;   // idle line is mark.
            busy     <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (start) begin
                        state <= tx_start;
                        line  <= 1'b0;      // start bit goes out right away.
                        busy  <= 1'b1;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state    <= tx_data;
                        baud_cnt <= '0;
                        line     <= shift_q[0];   // lsb first.
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'(data_bits - 1)) begin
                            state <= tx_stop;
                            line  <= 1'b1;        // stop bit.
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            line    <= shift_q[0];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                tx_stop: begin
                    if (bit_end) begin
                        state    <= tx_idle;
                        baud_cnt <= '0;
                        busy     <= 1'b0;   // line stays high.
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= tx_idle;
                    line  <= 1'b1;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // payload shifter, no reset needed.
    // loaded on accept, then drops one bit each time a data bit is put on the line.
    always_ff @(posedge clk) begin
        if (state == tx_idle && start) begin
            shift_q <= byte_in;
        end else if (bit_end && (state == tx_start || state == tx_data)) begin
            shift_q <= shift_q >> 1;
        end
    end

    // the top must hold off its strobe until the frame in flight is done.
    a_no_start_while_busy : assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    ) else $error("uart_tx: start strobe while busy.");

endmodule : uart_tx

/* hw/uart_rx.sv */
/* 8N1 deserializer with a two-flop synchronizer and mid-bit sampling, no oversampling
   vote. done or frame_bad pulses about 2-4 cycles after the middle of the stop bit. */

`timescale 1ns/1ps

module uart_rx (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  line,        // asynchronous serial input.
    output uart_pkg::uart_byte_t  byte_out,    // valid while done is high.
    output logic                  done,        // one-cycle pulse, good frame.
    output logic                  frame_bad    // one-cycle pulse, stop bit low.
);

    import uart_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input synchronizer and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic sync_q1;    // first flop, may go metastable.
    logic line_s;     // synchronized line.
    logic line_d;     // previous synchronized value.
    logic fall;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q1 <= 1'b1;   // preset to the idle level.
            line_s  <= 1'b1;
            line_d  <= 1'b1;
        end else begin
            sync_q1 <= line;
            line_s  <= sync_q1;
            line_d  <= line_s;
        end
    end

    // high-to-low transition, a candidate start bit.
    assign fall = line_d & ~line_s;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rx_state_t  state;
    baud_cnt_t  baud_cnt;      // cycles since the last sample point.
    logic [2:0] bit_idx;       // data bit being received.
    uart_byte_t shift_q;       // data bits, msb side filled first.
    logic       mid_start;     // middle of the start bit.
    logic       mid_bit;       // middle of a data or stop bit.

    assign mid_start = (baud_cnt == baud_cnt_t'(half_bit - 1));
    assign mid_bit   = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= rx_idle;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_bad <= 1'b0;
        end else begin
            done      <= 1'b0;   // both flags are single-cycle.
            frame_bad <= 1'b0;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (fall) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (mid_start) begin
                        baud_cnt <= '0;
                        // a line back high at mid-start was a glitch.
                        state <= line_s ? rx_idle : rx_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (mid_bit) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'(data_bits - 1)) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (mid_bit) begin
                        baud_cnt  <= '0;
                        state     <= rx_idle;   // rest of the stop bit is ignored.
                        done      <= line_s;
                        frame_bad <= ~line_s;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // payload, shifted in lsb first at each data mid-bit.
    always_ff @(posedge clk) begin
        if (state == rx_data && mid_bit) begin
            shift_q <= {line_s, shift_q[7:1]};
        end
    end

    assign byte_out = shift_q;   // stable from the last data bit through done.

    // a frame ends either good or bad, never both.
    a_done_xor_bad : assert property (
        @(posedge clk) disable iff (reset) !(done && frame_bad)
    ) else $error("uart_rx: done and frame_bad together.");

endmodule : uart_rx

/* hw/uart_top.sv */
/* UART top with a single-byte receive holding register; no FIFO and no flow control.
   bytes offered with tx_valid while the transmitter is busy are dropped. */

`timescale 1ns/1ps

module uart_top (
    input  logic                  clk,
    input  logic                  reset,

    // transmit side.
    input  uart_pkg::uart_byte_t  tx_data,        // sampled when accepted.
    input  logic                  tx_valid,       // request to send tx_data.
    output logic                  tx_busy,        // frame in progress.
    output logic                  tx_line,        // serial output.

    // receive side.
    input  logic                  rx_line,        // serial input, asynchronous.
    input  logic                  rx_clear,       // rising edge acknowledges the byte.
    output uart_pkg::uart_byte_t  rx_data,        // last good byte.
    output logic                  rx_ready,       // new byte waiting.
    output logic                  rx_overrun,     // byte arrived while rx_ready was set.
    output logic                  rx_frame_err    // sticky, stop bit seen low.
);

    import uart_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit accept
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic       tx_start;   // one-cycle strobe into the serializer.
    uart_byte_t tx_byte;    // byte held for the serializer.
    logic       tx_accept;

    // busy is still low while the strobe is in flight, so the strobe blocks too.
    assign tx_accept = tx_valid & ~tx_busy & ~tx_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= tx_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_byte <= tx_data;
        end
    end

    uart_tx u_tx (
        .clk     (clk),
        .reset   (reset),
        .start   (tx_start),
        .byte_in (tx_byte),
        .line    (tx_line),
        .busy    (tx_busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive path and status flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    uart_byte_t rx_byte;        // deserializer output, valid with rx_done.
    logic       rx_done;
    logic       rx_frame_bad;
    logic       rx_clear_q;     // previous rx_clear for edge detect.
    logic       clear_rise;

    uart_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .line      (rx_line),
        .byte_out  (rx_byte),
        .done      (rx_done),
        .frame_bad (rx_frame_bad)
    );

    assign clear_rise = rx_clear & ~rx_clear_q;   // a held clear acts once.

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_clear_q   <= 1'b0;
            rx_ready     <= 1'b0;
            rx_overrun   <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_clear_q <= rx_clear;

            // a new byte beats a clear in the same cycle.
            if (rx_done) begin
                rx_ready <= 1'b1;
            end else if (clear_rise) begin
                rx_ready <= 1'b0;
            end

            // the old byte counts as read when the clear comes with the new one.
            if (rx_done && rx_ready && !clear_rise) begin
                rx_overrun <= 1'b1;
            end else if (clear_rise) begin
                rx_overrun <= 1'b0;
            end

            if (rx_frame_bad) begin
                rx_frame_err <= 1'b1;   // ready and data untouched.
            end else if (clear_rise) begin
                rx_frame_err <= 1'b0;
            end
        end
    end

    // holding register, overwritten on every good frame.
    always_ff @(posedge clk) begin
        if (rx_done) begin
            rx_data <= rx_byte;
        end
    end

    // overrun only exists on top of an unread byte.
    a_overrun_needs_ready : assert property (
        @(posedge clk) disable iff (reset) rx_overrun |-> rx_ready
    ) else $error("uart_top: rx_overrun without rx_ready.");

endmodule : uart_top

/* verification/uart_tb_checks.sv */
/* assertion checker for the uart_core testbench. the receive model expects no clear
   edge within a few cycles of a stop bit, and decodes tx_line at mid-bit after busy rises. */

`timescale 1ns/1ps

module uart_tb_checks (
    input  logic                  clk,
    input  logic                  reset,
    input  uart_pkg::uart_byte_t  tx_data,
    input  logic                  tx_valid,
    input  logic                  tx_busy,
    input  logic                  tx_line,
    input  logic                  rx_clear,
    input  uart_pkg::uart_byte_t  rx_data,
    input  logic                  rx_ready,
    input  logic                  rx_overrun,
    input  logic                  rx_frame_err,
    input  logic                  sent_mid,     // driver sits at the middle of a stop bit.
    input  uart_pkg::uart_byte_t  sent_byte,    // byte of that frame.
    input  logic                  sent_good,    // stop bit was driven high.
    output logic                  failed        // goes high at the first failed check.
);

    import uart_pkg::*;

    logic failed_q = 1'b0;
    assign failed = failed_q;

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        failed_q = 1'b1;
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        failed_q = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit model and line decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic        tx_pending;   // byte accepted, frame not started yet.
    uart_byte_t  tx_expect;    // byte that the next frame must carry.
    uart_byte_t  tx_shift;     // bits decoded from the line, lsb first.
    int unsigned busy_len;     // busy samples so far in this frame.
    int          tx_bit;       // frame bit under the current sample.
    logic        tx_mid;

    assign tx_mid = tx_busy && (busy_len % clks_per_bit == half_bit);
    assign tx_bit = busy_len / clks_per_bit;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_pending <= 1'b0;
            busy_len   <= 0;
        end else begin
            // accepted only when idle and no start is already on its way.
            if (tx_valid && !tx_busy && !tx_pending) begin
                tx_pending <= 1'b1;
                tx_expect  <= tx_data;
            end else if (tx_busy) begin
                tx_pending <= 1'b0;
            end
            busy_len <= tx_busy ? busy_len + 1 : 0;
            if (tx_mid && tx_bit >= 1 && tx_bit <= data_bits) begin
                tx_shift <= {tx_line, tx_shift[7:1]};   // first bit ends up in bit 0.
            end
        end
    end

    // line rests at mark whenever no frame is in flight.
    a_tx_idle_high : assert property (
        @(posedge clk) disable iff (reset) !tx_busy |-> tx_line
    ) else report_mismatch("tx idle line", 32'd1, 32'($sampled(tx_line)));

    a_tx_start_bit : assert property (
        @(posedge clk) disable iff (reset) (tx_mid && tx_bit == 0) |-> !tx_line
    ) else report_mismatch("tx start bit", 32'd0, 32'($sampled(tx_line)));

    a_tx_stop_bit : assert property (
        @(posedge clk) disable iff (reset) (tx_mid && tx_bit == data_bits + 1) |-> tx_line
    ) else report_mismatch("tx stop bit", 32'd1, 32'($sampled(tx_line)));

    // whole byte is in by the middle of the stop bit.
    a_tx_byte : assert property (
        @(posedge clk) disable iff (reset)
            (tx_mid && tx_bit == data_bits + 1) |-> tx_shift == tx_expect
    ) else report_mismatch("tx data", 32'($sampled(tx_expect)), 32'($sampled(tx_shift)));

    a_tx_busy_len : assert property (
        @(posedge clk) disable iff (reset) $fell(tx_busy) |-> busy_len == frame_clks
    ) else report_mismatch("tx busy length", 32'(frame_clks), 32'($sampled(busy_len)));

    a_tx_no_extra_frame : assert property (
        @(posedge clk) disable iff (reset) $rose(tx_busy) |-> tx_pending
    ) else report_error("a transmit frame started without an accepted byte.");

    a_tx_frame_follows : assert property (
        @(posedge clk) disable iff (reset) $rose(tx_pending) |=> $rose(tx_busy)
    ) else report_error("an accepted byte did not start a transmit frame.");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive status model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic       clear_q;
    logic       exp_ready;
    logic       exp_overrun;
    logic       exp_frame_err;
    logic       exp_has_data;   // a good byte was sent at least once.
    logic       data_valid;     // rx_data has settled on a real byte.
    uart_byte_t exp_data;
    logic [2:0] rx_age;         // cycles since the stop-bit middle, saturates at 7.
    logic       rx_settled;

    assign rx_settled = (rx_age >= 3'd4);   // ready is at most 5 cycles after mid-stop.

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_q       <= 1'b0;
            exp_ready     <= 1'b0;
            exp_overrun   <= 1'b0;
            exp_frame_err <= 1'b0;
            exp_has_data  <= 1'b0;
            data_valid    <= 1'b0;
            rx_age        <= 3'd7;
        end else begin
            clear_q <= rx_clear;
            if (sent_mid) begin
                rx_age <= 3'd0;
                if (sent_good) begin
                    exp_overrun  <= exp_overrun | exp_ready;   // unread byte gets lost.
                    exp_ready    <= 1'b1;
                    exp_data     <= sent_byte;
                    exp_has_data <= 1'b1;
                end else begin
                    exp_frame_err <= 1'b1;   // sticky.
                end
            end else begin
                if (rx_age != 3'd7) begin
                    rx_age <= rx_age + 3'd1;
                end
                if (rx_clear && !clear_q) begin
                    exp_ready     <= 1'b0;
                    exp_overrun   <= 1'b0;
                    exp_frame_err <= 1'b0;
                end
            end
            if (rx_age == 3'd7 && exp_has_data) begin
                data_valid <= 1'b1;
            end
        end
    end

    a_rx_ready : assert property (
        @(posedge clk) disable iff (reset) rx_settled |-> rx_ready == exp_ready
    ) else report_mismatch("rx ready", 32'($sampled(exp_ready)), 32'($sampled(rx_ready)));

    a_rx_overrun : assert property (
        @(posedge clk) disable iff (reset) rx_settled |-> rx_overrun == exp_overrun
    ) else report_mismatch("rx overrun", 32'($sampled(exp_overrun)),
                           32'($sampled(rx_overrun)));

    a_rx_frame_err : assert property (
        @(posedge clk) disable iff (reset) rx_settled |-> rx_frame_err == exp_frame_err
    ) else report_mismatch("rx framing error", 32'($sampled(exp_frame_err)),
                           32'($sampled(rx_frame_err)));

    a_rx_data : assert property (
        @(posedge clk) disable iff (reset) (rx_settled && exp_has_data) |-> rx_data == exp_data
    ) else report_mismatch("rx data", 32'($sampled(exp_data)), 32'($sampled(rx_data)));

    // nothing moves before the receiver can have seen the stop bit.
    a_rx_not_early : assert property (
        @(posedge clk) disable iff (reset)
            (rx_age <= 3'd1) |-> !$rose(rx_ready) && !$rose(rx_frame_err)
    ) else report_error("receive status changed before the stop bit was sampled.");

    a_rx_data_not_early : assert property (
        @(posedge clk) disable iff (reset) (rx_age <= 3'd1 && data_valid) |-> $stable(rx_data)
    ) else report_error("rx_data changed before the stop bit was sampled.");

endmodule : uart_tb_checks

/* verification/uart_tb.sv */
/* testbench for uart_top; inputs change on the rising edge and the checker does all
   comparing. receive frames are driven at exactly clks_per_bit cycles per bit. */

`timescale 1ns/1ps

module uart_tb;

    import uart_pkg::*;

    logic        clk;
    logic        reset;
    uart_byte_t  tx_data;
    logic        tx_valid;
    logic        tx_busy;
    logic        tx_line;
    logic        rx_line;
    logic        rx_clear;
    uart_byte_t  rx_data;
    logic        rx_ready;
    logic        rx_overrun;
    logic        rx_frame_err;
    logic        sent_mid;       // one cycle at the middle of each stop bit sent.
    uart_byte_t  sent_byte;
    logic        sent_good;
    logic        check_failed;
    uart_byte_t  first_byte;
    int unsigned cycles = 0;

    uart_top dut (
        .clk          (clk),
        .reset        (reset),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_busy      (tx_busy),
        .tx_line      (tx_line),
        .rx_line      (rx_line),
        .rx_clear     (rx_clear),
        .rx_data      (rx_data),
        .rx_ready     (rx_ready),
        .rx_overrun   (rx_overrun),
        .rx_frame_err (rx_frame_err)
    );

    uart_tb_checks u_checks (
        .clk (clk), .reset (reset),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_busy (tx_busy), .tx_line (tx_line),
        .rx_clear (rx_clear), .rx_data (rx_data), .rx_ready (rx_ready),
        .rx_overrun (rx_overrun), .rx_frame_err (rx_frame_err),
        .sent_mid (sent_mid), .sent_byte (sent_byte), .sent_good (sent_good),
        .failed (check_failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period.
    end

    // run limit, 40 frames plus slack.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 40 * frame_clks + 100) begin
            $display("TEST FAILED");
            $fatal(1, "timeout, the stimulus did not finish within %0d cycles.", cycles);
        end
    end

    initial begin
        wait (check_failed === 1'b1);
        $display("TEST FAILED");
        $fatal(1, "a check in the checker failed.");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers, all entered right after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_busy(input logic level);
        do @(posedge clk); while (tx_busy !== level);
    endtask

    // offer one byte while idle and wait for its frame to end.
    task automatic send_tx(input uart_byte_t b);
        while (tx_busy) @(posedge clk);
        tx_data  <= b;
        tx_valid <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
    endtask

    // one 8N1 frame on rx_line, stop bit low when good is 0.
    task automatic send_rx(input uart_byte_t b, input logic good);
        logic [9:0] frame;
        frame = {good, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line <= frame[i];
            for (int c = 0; c < clks_per_bit; c++) begin
                if (i == 9 && c == half_bit) begin
                    sent_mid  <= 1'b1;   // tell the checker what went out.
                    sent_byte <= b;
                    sent_good <= good;
                end else begin
                    sent_mid <= 1'b0;
                end
                @(posedge clk);
            end
        end
        rx_line  <= 1'b1;
        sent_mid <= 1'b0;
    endtask

    task automatic pulse_clear();
        rx_clear <= 1'b1;
        @(posedge clk);
        rx_clear <= 1'b0;
        @(posedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h01b1_4388));
        reset     = 1'b1;
        tx_data   = '0;
        tx_valid  = 1'b0;
        rx_line   = 1'b1;   // idle mark.
        rx_clear  = 1'b0;
        sent_mid  = 1'b0;
        sent_byte = '0;
        sent_good = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        repeat (8) send_tx(uart_byte_t'($urandom));   // transmit frames.

        // valid held over a frame; the byte offered while busy goes out next.
        tx_data  <= uart_byte_t'($urandom);
        tx_valid <= 1'b1;
        wait_busy(1'b1);
        tx_data <= uart_byte_t'($urandom);
        wait_busy(1'b0);
        wait_busy(1'b1);
        tx_valid <= 1'b0;
        wait_busy(1'b0);

        // a lone strobe in mid-frame is dropped.
        tx_data  <= uart_byte_t'($urandom);
        tx_valid <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
        wait_busy(1'b1);
        repeat (frame_clks / 2) @(posedge clk);
        tx_data  <= uart_byte_t'($urandom);
        tx_valid <= 1'b1;
        @(posedge clk);
        tx_valid <= 1'b0;
        wait_busy(1'b0);

        // receive with a clear after each byte.
        send_rx(uart_byte_t'($urandom), 1'b1);
        pulse_clear();
        send_rx(uart_byte_t'($urandom), 1'b1);
        pulse_clear();

        // a held clear acts once; the next byte stays ready until a new edge.
        send_rx(uart_byte_t'($urandom), 1'b1);
        rx_clear <= 1'b1;
        repeat (4) @(posedge clk);
        send_rx(uart_byte_t'($urandom), 1'b1);
        rx_clear <= 1'b0;
        @(posedge clk);
        pulse_clear();

        // overrun, two different bytes without a clear.
        first_byte = uart_byte_t'($urandom);
        send_rx(first_byte, 1'b1);
        send_rx(first_byte ^ 8'h5a, 1'b1);
        pulse_clear();

        // framing error keeps the good byte and its ready flag.
        send_rx(uart_byte_t'($urandom), 1'b1);
        send_rx(uart_byte_t'($urandom), 1'b0);
        repeat (4) @(posedge clk);
        pulse_clear();
        repeat (8) @(posedge clk);   // let the last settled checks run.

        if (check_failed) begin
            $display("TEST FAILED");
            $fatal(1, "a check failed during the run.");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule : uart_tb

/* uart_core.f */
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verification/uart_tb_checks.sv
verification/uart_tb.sv

/* run_uart_core.sh */
#!/bin/sh
# Build the uart_core testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module uart_tb \
    -f uart_core.f \
    -o sim_uart_core

./obj_dir/sim_uart_core
